//--- rtl/pio_pkg.sv
`default_nettype none

package pio_pkg;

  localparam int data_width = 32;

  typedef logic [data_width-1:0] word_t;
  typedef logic [4:0]            addr_t;
  typedef logic [5:0]            count_t; // 1 to 32, encoded 0 is 32

  // Instruction field positions
  localparam int opcode_lsb = 13; // Bits 15 to 13
  localparam int delay_lsb  = 8;  // Bits 12 to 8
  localparam int op1_lsb    = 5;  // Bits 7 to 5, op2 in bits 4 to 0

  typedef enum logic [2:0] {
    op_jmp       = 3'd0,
    op_wait      = 3'd1,
    op_in        = 3'd2,
    op_out       = 3'd3,
    op_push_pull = 3'd4,
    op_mov       = 3'd5,
    op_irq       = 3'd6,
    op_set       = 3'd7
  } opcode_e;

  typedef enum logic [2:0] {
    cond_always = 3'd0,
    cond_x_zero = 3'd1,
    cond_x_dec  = 3'd2,
    cond_y_zero = 3'd3,
    cond_y_dec  = 3'd4,
    cond_x_ne_y = 3'd5,
    cond_pin    = 3'd6
  } jmp_cond_e;

  typedef enum logic [2:0] {
    in_src_pins = 3'd0,
    in_src_x    = 3'd1,
    in_src_y    = 3'd2,
    in_src_null = 3'd3,
    in_src_isr  = 3'd6,
    in_src_osr  = 3'd7
  } in_src_e;

  typedef enum logic [2:0] {
    out_dst_pins    = 3'd0,
    out_dst_x       = 3'd1,
    out_dst_y       = 3'd2,
    out_dst_pindirs = 3'd4,
    out_dst_pc      = 3'd5,
    out_dst_isr     = 3'd6
  } out_dest_e;

  typedef enum logic [2:0] {
    set_dst_pins    = 3'd0,
    set_dst_x       = 3'd1,
    set_dst_y       = 3'd2,
    set_dst_pindirs = 3'd4
  } set_dest_e;

endpackage

`default_nettype wire

//--- rtl/shift_in_unit.sv
`timescale 1ns/1ps
`default_nettype none

module shift_in_unit (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   shift_in,
  input  wire                   clear_isr,
  input  wire pio_pkg::word_t   in_data,
  input  wire pio_pkg::count_t  shift_count,
  input  wire                   in_shift_dir, // 1 shifts right
  output pio_pkg::word_t        isr
);
  import pio_pkg::*;

  word_t mask;    // Low shift_count bits
  word_t shifted;

  assign mask = ~({data_width{1'b1}} << shift_count);

  always_comb begin
    if (in_shift_dir) begin
      // New bits enter at the top
      shifted = (isr >> shift_count) | (in_data << (data_width - int'(shift_count)));
    end else begin
      shifted = (isr << shift_count) | (in_data & mask);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      isr <= '0;
    end else if (clear_isr) begin
      isr <= shift_in ? (in_data & mask) : '0; // Load from OUT, else cleared by push
    end else if (shift_in) begin
      isr <= shifted;
    end
  end

endmodule

`default_nettype wire

//--- rtl/shift_out_unit.sv
`timescale 1ns/1ps
`default_nettype none

module shift_out_unit (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   shift_out,
  input  wire                   load_osr,
  input  wire pio_pkg::word_t   new_val,
  input  wire pio_pkg::count_t  shift_count,
  input  wire                   out_shift_dir, // 1 shifts right
  output pio_pkg::word_t        osr,
  output pio_pkg::word_t        out_data
);
  import pio_pkg::*;

  word_t mask;

  assign mask = ~({data_width{1'b1}} << shift_count);

  // Next bits, right-aligned
  always_comb begin
    if (out_shift_dir) begin
      out_data = osr & mask;
    end else begin
      out_data = osr >> (data_width - int'(shift_count));
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      osr <= '0;
    end else if (load_osr) begin
      osr <= new_val;
    end else if (shift_out) begin
      if (out_shift_dir) begin
        osr <= osr >> shift_count; // Zero fill
      end else begin
        osr <= osr << shift_count;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/scratch_regs.sv
`timescale 1ns/1ps
`default_nettype none

module scratch_regs (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   set_x,
  input  wire                   set_y,
  input  wire                   dec_x,
  input  wire                   dec_y,
  input  wire pio_pkg::word_t   new_val,
  output pio_pkg::word_t        x,
  output pio_pkg::word_t        y
);
  import pio_pkg::*;

  word_t x_next;
  word_t y_next;

  // Set wins over decrement
  always_comb begin
    x_next = x;
    y_next = y;
    if (set_x) begin
      x_next = new_val;
    end else if (dec_x) begin
      x_next = x - 1'b1;
    end
    if (set_y) begin
      y_next = new_val;
    end else if (dec_y) begin
      y_next = y - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      x <= '0;
      y <= '0;
    end else begin
      x <= x_next;
      y <= y_next;
    end
  end

endmodule

`default_nettype wire

//--- rtl/program_counter.sv
`timescale 1ns/1ps
`default_nettype none

module program_counter (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   en,
  input  wire                   stall,       // Delay or blocked FIFO
  input  wire                   jmp,
  input  wire pio_pkg::addr_t   jmp_target,
  input  wire pio_pkg::addr_t   pend,
  input  wire pio_pkg::addr_t   wrap_target,
  output pio_pkg::addr_t        pc
);
  import pio_pkg::*;

  addr_t pc_inc;

  assign pc_inc = (pc == pend) ? wrap_target : pc + 1'b1; // Program wrap

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (jmp) begin
      pc <= jmp_target;
    end else if (en && !stall) begin
      pc <= pc_inc;
    end
  end

endmodule

`default_nettype wire

//--- rtl/exec_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module exec_ctrl #(
  parameter int pin_count = 32
) (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   en,
  input  wire [15:0]            instr,
  input  wire pio_pkg::word_t   x,
  input  wire pio_pkg::word_t   y,
  input  wire pio_pkg::word_t   isr,
  input  wire pio_pkg::word_t   osr,
  input  wire pio_pkg::word_t   out_data,
  input  wire pio_pkg::word_t   din,
  input  wire                   empty,
  input  wire                   full,
  input  wire pio_pkg::word_t   input_pins,
  input  wire                   jmp_pin,
  input  wire [4:0]             pins_out_base,
  input  wire [5:0]             pins_out_count,
  input  wire [4:0]             pins_set_base,
  input  wire [2:0]             pins_set_count,
  input  wire [4:0]             pins_in_base,
  output logic                  set_x,
  output logic                  set_y,
  output logic                  dec_x,
  output logic                  dec_y,
  output pio_pkg::word_t        new_val,
  output logic                  shift_in,
  output logic                  clear_isr,
  output pio_pkg::word_t        in_data,
  output pio_pkg::count_t       shift_count,
  output logic                  shift_out,
  output logic                  load_osr,
  output logic                  jmp,
  output pio_pkg::addr_t        jmp_target,
  output logic                  stall,
  output logic                  push,
  output logic                  pull,
  output pio_pkg::word_t        dout,
  output logic [pin_count-1:0]  output_pins,
  output logic [pin_count-1:0]  pin_directions
);
  import pio_pkg::*;

  opcode_e    op;
  logic [4:0] delay;
  logic [2:0] op1;
  logic [4:0] op2;
  logic [4:0] delay_cnt;
  logic       active;    // Instruction executes this cycle
  logic       waiting;   // Blocked on FIFO
  word_t      in_pins;   // Rotated so pins_in_base lands at bit 0
  logic       wr_pins;
  logic       wr_dirs;
  logic [4:0] wr_base;
  logic [5:0] wr_count;
  word_t      wr_val;

  assign op          = opcode_e'(instr[opcode_lsb +: 3]);
  assign delay       = instr[delay_lsb +: 5];
  assign op1         = instr[op1_lsb +: 3];
  assign op2         = instr[4:0];
  assign active      = en && (delay_cnt == '0);
  assign stall       = (delay_cnt != '0) || waiting;
  assign shift_count = (op2 == '0) ? count_t'(data_width) : count_t'(op2);

  always_comb begin
    in_pins = '0;
    for (int i = 0; i < pin_count; i++) begin
      in_pins[i] = input_pins[(int'(pins_in_base) + i) % pin_count];
    end
  end

  always_comb begin
    set_x      = 1'b0;
    set_y      = 1'b0;
    dec_x      = 1'b0;
    dec_y      = 1'b0;
    shift_in   = 1'b0;
    clear_isr  = 1'b0;
    shift_out  = 1'b0;
    load_osr   = 1'b0;
    jmp        = 1'b0;
    push       = 1'b0;
    pull       = 1'b0;
    waiting    = 1'b0;
    wr_pins    = 1'b0;
    wr_dirs    = 1'b0;
    new_val    = word_t'(op2);
    in_data    = '0;
    dout       = '0;
    jmp_target = op2;
    wr_base    = pins_set_base;
    wr_count   = {3'b000, pins_set_count};
    wr_val     = word_t'(op2);
    if (active) begin
      case (op)
        op_jmp: begin
          case (jmp_cond_e'(op1))
            cond_always: jmp = 1'b1;
            cond_x_zero: jmp = (x == '0);
            cond_x_dec: begin
              jmp   = (x != '0);
              dec_x = (x != '0); // Stops at zero
            end
            cond_y_zero: jmp = (y == '0);
            cond_y_dec: begin
              jmp   = (y != '0);
              dec_y = (y != '0);
            end
            cond_x_ne_y: jmp = (x != y);
            cond_pin:    jmp = jmp_pin;
            default:     jmp = 1'b0; // OSR count condition not supported
          endcase
        end
        op_in: begin
          shift_in = 1'b1;
          case (in_src_e'(op1))
            in_src_pins: in_data = in_pins;
            in_src_x:    in_data = x;
            in_src_y:    in_data = y;
            in_src_null: in_data = '0;
            in_src_isr:  in_data = isr;
            in_src_osr:  in_data = osr;
            default:     shift_in = 1'b0; // Reserved source
          endcase
        end
        op_out: begin
          shift_out = 1'b1;
          new_val   = out_data;
          in_data   = out_data;
          wr_base   = pins_out_base;
          wr_count  = pins_out_count;
          wr_val    = out_data;
          case (out_dest_e'(op1))
            out_dst_pins:    wr_pins = 1'b1;
            out_dst_x:       set_x = 1'b1;
            out_dst_y:       set_y = 1'b1;
            out_dst_pindirs: wr_dirs = 1'b1;
            out_dst_pc: begin
              jmp        = 1'b1;
              jmp_target = out_data[4:0];
            end
            out_dst_isr: begin
              shift_in  = 1'b1; // Together with clear, loads the ISR
              clear_isr = 1'b1;
            end
            default: wr_pins = 1'b0; // Shifted bits are discarded
          endcase
        end
        op_push_pull: begin
          if (!op1[2]) begin // PUSH
            if (!full) begin
              push      = 1'b1;
              dout      = isr;
              clear_isr = 1'b1;
            end else begin
              waiting = op1[0]; // Block bit
            end
          end else if (!empty) begin // PULL
            pull     = 1'b1;
            load_osr = 1'b1;
            new_val  = din;
          end else if (op1[0]) begin
            waiting = 1'b1;
          end else begin
            load_osr = 1'b1; // Non-blocking on empty takes X
            new_val  = x;
          end
        end
        op_set: begin
          case (set_dest_e'(op1))
            set_dst_pins:    wr_pins = 1'b1;
            set_dst_x:       set_x = 1'b1;
            set_dst_y:       set_y = 1'b1;
            set_dst_pindirs: wr_dirs = 1'b1;
            default:         wr_pins = 1'b0;
          endcase
        end
        default: waiting = 1'b0; // WAIT, MOV and IRQ do nothing
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      delay_cnt <= '0;
    end else if (en) begin
      if (delay_cnt != '0) begin
        delay_cnt <= delay_cnt - 1'b1;
      end else if (!waiting) begin
        delay_cnt <= delay; // Idle cycles after this instruction
      end
    end
  end

  // Window writes wrap modulo pin_count
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      output_pins    <= '0;
      pin_directions <= '0;
    end else begin
      for (int i = 0; i < pin_count; i++) begin
        if (i < int'(wr_count)) begin
          if (wr_pins) output_pins[(int'(wr_base) + i) % pin_count] <= wr_val[i];
          if (wr_dirs) pin_directions[(int'(wr_base) + i) % pin_count] <= wr_val[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/pio_machine.sv
`timescale 1ns/1ps
`default_nettype none

module pio_machine #(
  parameter int pin_count = 32
) (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   en,            // Step strobe
  input  wire [15:0]            instr,
  input  wire pio_pkg::word_t   din,
  input  wire                   empty,
  input  wire                   full,
  input  wire pio_pkg::word_t   input_pins,
  input  wire                   jmp_pin,
  input  wire pio_pkg::addr_t   pend,
  input  wire pio_pkg::addr_t   wrap_target,
  input  wire [4:0]             pins_out_base,
  input  wire [5:0]             pins_out_count,
  input  wire [4:0]             pins_set_base,
  input  wire [2:0]             pins_set_count,
  input  wire [4:0]             pins_in_base,
  input  wire                   in_shift_dir,  // 1 shifts right
  input  wire                   out_shift_dir, // 1 shifts right
  output wire pio_pkg::addr_t   pc,
  output wire                   push,
  output wire                   pull,
  output wire pio_pkg::word_t   dout,
  output wire [pin_count-1:0]   output_pins,
  output wire [pin_count-1:0]   pin_directions
);
  import pio_pkg::*;

  word_t  x;
  word_t  y;
  word_t  isr;
  word_t  osr;
  word_t  out_data;
  word_t  new_val;
  word_t  in_data;
  count_t shift_count;
  addr_t  jmp_target;
  logic   set_x;
  logic   set_y;
  logic   dec_x;
  logic   dec_y;
  logic   shift_in;
  logic   clear_isr;
  logic   shift_out;
  logic   load_osr;
  logic   jmp;
  logic   stall;

  exec_ctrl #(
    .pin_count (pin_count)
  ) i_exec_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .en             (en),
    .instr          (instr),
    .x              (x),
    .y              (y),
    .isr            (isr),
    .osr            (osr),
    .out_data       (out_data),
    .din            (din),
    .empty          (empty),
    .full           (full),
    .input_pins     (input_pins),
    .jmp_pin        (jmp_pin),
    .pins_out_base  (pins_out_base),
    .pins_out_count (pins_out_count),
    .pins_set_base  (pins_set_base),
    .pins_set_count (pins_set_count),
    .pins_in_base   (pins_in_base),
    .set_x          (set_x),
    .set_y          (set_y),
    .dec_x          (dec_x),
    .dec_y          (dec_y),
    .new_val        (new_val),
    .shift_in       (shift_in),
    .clear_isr      (clear_isr),
    .in_data        (in_data),
    .shift_count    (shift_count),
    .shift_out      (shift_out),
    .load_osr       (load_osr),
    .jmp            (jmp),
    .jmp_target     (jmp_target),
    .stall          (stall),
    .push           (push),
    .pull           (pull),
    .dout           (dout),
    .output_pins    (output_pins),
    .pin_directions (pin_directions)
  );

  shift_in_unit i_shift_in_unit (
    .clk          (clk),
    .rst_n        (rst_n),
    .shift_in     (shift_in),
    .clear_isr    (clear_isr),
    .in_data      (in_data),
    .shift_count  (shift_count),
    .in_shift_dir (in_shift_dir),
    .isr          (isr)
  );

  shift_out_unit i_shift_out_unit (
    .clk           (clk),
    .rst_n         (rst_n),
    .shift_out     (shift_out),
    .load_osr      (load_osr),
    .new_val       (new_val),
    .shift_count   (shift_count),
    .out_shift_dir (out_shift_dir),
    .osr           (osr),
    .out_data      (out_data)
  );

  scratch_regs i_scratch_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .set_x   (set_x),
    .set_y   (set_y),
    .dec_x   (dec_x),
    .dec_y   (dec_y),
    .new_val (new_val),
    .x       (x),
    .y       (y)
  );

  program_counter i_program_counter (
    .clk         (clk),
    .rst_n       (rst_n),
    .en          (en),
    .stall       (stall),
    .jmp         (jmp),
    .jmp_target  (jmp_target),
    .pend        (pend),
    .wrap_target (wrap_target),
    .pc          (pc)
  );

endmodule

`default_nettype wire

//--- tests/pio_machine_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module pio_machine_assertions #(
  parameter int pin_count = 32
) (
  input wire                   clk,
  input wire                   rst_n,
  input wire                   en,
  input wire [15:0]            instr,
  input wire pio_pkg::word_t   din,
  input wire                   empty,
  input wire                   full,
  input wire pio_pkg::addr_t   pend,
  input wire pio_pkg::addr_t   wrap_target,
  input wire [4:0]             pins_out_base,
  input wire [5:0]             pins_out_count,
  input wire [4:0]             pins_set_base,
  input wire [2:0]             pins_set_count,
  input wire pio_pkg::addr_t   pc,
  input wire                   push,
  input wire                   pull,
  input wire pio_pkg::word_t   dout,
  input wire [pin_count-1:0]   output_pins,
  input wire [pin_count-1:0]   pin_directions
);
  import pio_pkg::*;

  int                   error_count = 0;
  word_t                last_pull;   // din taken at the latest pull
  logic                 pull_seen;
  logic                 is_jump;     // JMP or OUT PC
  logic [pin_count-1:0] fixed_mask;  // Pins outside both windows

  assign is_jump = (instr[15:13] == op_jmp) ||
                   ((instr[15:13] == op_out) && (instr[7:5] == out_dst_pc));

  always_comb begin
    fixed_mask = '1;
    for (int i = 0; i < pin_count; i++) begin
      if (i < int'(pins_set_count)) fixed_mask[(int'(pins_set_base) + i) % pin_count] = 1'b0;
      if (i < int'(pins_out_count)) fixed_mask[(int'(pins_out_base) + i) % pin_count] = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_pull <= '0;
      pull_seen <= 1'b0;
    end else if (pull) begin
      last_pull <= din;
      pull_seen <= 1'b1;
    end
  end

  a_reset_state: assert property (@(posedge clk)
    !rst_n |=> (pc == '0 && output_pins == '0 && pin_directions == '0))
    else begin
      $error("[ERROR] after reset pc=0x%02h output_pins=0x%08h pin_directions=0x%08h",
             pc, output_pins, pin_directions);
      error_count++;
    end

  a_reset_strobes: assert property (@(posedge clk) !rst_n |-> (!push && !pull))
    else begin
      $error("[ERROR] in reset push=0x%01h pull=0x%01h expected 0x0", push, pull);
      error_count++;
    end

  a_push_not_full: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full)
    else begin
      $error("push was high while the FIFO was full");
      error_count++;
    end

  a_pull_not_empty: assert property (@(posedge clk) disable iff (!rst_n) pull |-> !empty)
    else begin
      $error("pull was high while the FIFO was empty");
      error_count++;
    end

  // Loopback through OSR, X and ISR
  a_dout_loopback: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> (pull_seen && dout == last_pull))
    else begin
      $error("[ERROR] dout=0x%08h expected 0x%08h", dout, last_pull);
      error_count++;
    end

  a_pins_fixed: assert property (@(posedge clk) disable iff (!rst_n)
    $stable(output_pins & fixed_mask))
    else begin
      $error("[ERROR] output_pins=0x%08h changed outside mask 0x%08h", output_pins, fixed_mask);
      error_count++;
    end

  a_dirs_fixed: assert property (@(posedge clk) disable iff (!rst_n)
    $stable(pin_directions & fixed_mask))
    else begin
      $error("[ERROR] pin_directions=0x%08h changed outside mask 0x%08h",
             pin_directions, fixed_mask);
      error_count++;
    end

  a_pc_needs_en: assert property (@(posedge clk) disable iff (!rst_n) !en |=> $stable(pc))
    else begin
      $error("pc changed after a cycle with en low");
      error_count++;
    end

  a_pc_within_pend: assert property (@(posedge clk) disable iff (!rst_n) pc <= pend)
    else begin
      $error("[ERROR] pc=0x%02h beyond pend=0x%02h", pc, pend);
      error_count++;
    end

  // Leaving pend without a jump must land on wrap_target
  a_pc_wrap: assert property (@(posedge clk) disable iff (!rst_n)
    (pc == pend && !is_jump) |=> (pc == pend || pc == wrap_target))
    else begin
      $error("[ERROR] pc=0x%02h after pend, expected 0x%02h", pc, wrap_target);
      error_count++;
    end

endmodule

`default_nettype wire

//--- tests/pio_machine_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pio_machine_tb;
  import pio_pkg::*;

  localparam int pin_count   = 32;
  localparam int push_target = 20;
  // About 20 cycles per loop at 75% en plus FIFO stalls leaves wide margin
  localparam int max_cycles  = 2000;

  logic                 clk;
  logic                 rst_n;
  logic                 en;
  logic [15:0]          instr;
  word_t                din;
  logic                 empty;
  logic                 full;
  word_t                input_pins;
  logic                 jmp_pin;
  addr_t                pend;
  addr_t                wrap_target;
  logic [4:0]           pins_out_base;
  logic [5:0]           pins_out_count;
  logic [4:0]           pins_set_base;
  logic [2:0]           pins_set_count;
  logic [4:0]           pins_in_base;
  logic                 in_shift_dir;
  logic                 out_shift_dir;
  addr_t                pc;
  logic                 push;
  logic                 pull;
  word_t                dout;
  logic [pin_count-1:0] output_pins;
  logic [pin_count-1:0] pin_directions;

  logic [15:0] program_mem [0:31];
  word_t       fifo_words [0:7];
  integer      seed;
  int          cycle_count;
  int          push_count;
  int          rd_idx;      // Next FIFO word to offer on din
  logic        pull_taken;

  function automatic logic [15:0] instr_word(input opcode_e op, input logic [4:0] delay,
                                             input logic [2:0] op1, input logic [4:0] op2);
    return {op, delay, op1, op2};
  endfunction

  task automatic load_program();
    for (int a = 0; a < 32; a++) begin
      program_mem[a] = {3'b101, 8'h00, a[4:0]}; // MOV no-op tagged with its address
    end
    program_mem[0] = instr_word(op_set, 5'd0, set_dst_pindirs, 5'h1f);
    program_mem[1] = instr_word(op_set, 5'd3, set_dst_pins, 5'h15);
    program_mem[2] = instr_word(op_set, 5'd0, set_dst_x, 5'd3);
    program_mem[3] = instr_word(op_jmp, 5'd0, cond_x_dec, 5'd3); // Loop on itself
    program_mem[4] = instr_word(op_push_pull, 5'd0, 3'b101, 5'd0); // Blocking pull
    program_mem[5] = instr_word(op_out, 5'd0, out_dst_x, 5'd0);
    program_mem[6] = instr_word(op_in, 5'd0, in_src_x, 5'd0);
    program_mem[7] = instr_word(op_push_pull, 5'd0, 3'b001, 5'd0); // Blocking push
    program_mem[8] = instr_word(op_out, 5'd0, out_dst_pins, 5'd4);
    // Entry 9 stays a no-op at pend
  endtask

  assign instr = program_mem[pc];

  pio_machine #(
    .pin_count (pin_count)
  ) i_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .en             (en),
    .instr          (instr),
    .din            (din),
    .empty          (empty),
    .full           (full),
    .input_pins     (input_pins),
    .jmp_pin        (jmp_pin),
    .pend           (pend),
    .wrap_target    (wrap_target),
    .pins_out_base  (pins_out_base),
    .pins_out_count (pins_out_count),
    .pins_set_base  (pins_set_base),
    .pins_set_count (pins_set_count),
    .pins_in_base   (pins_in_base),
    .in_shift_dir   (in_shift_dir),
    .out_shift_dir  (out_shift_dir),
    .pc             (pc),
    .push           (push),
    .pull           (pull),
    .dout           (dout),
    .output_pins    (output_pins),
    .pin_directions (pin_directions)
  );

  bind pio_machine pio_machine_assertions #(
    .pin_count (pin_count)
  ) i_assertions (
    .clk            (clk),
    .rst_n          (rst_n),
    .en             (en),
    .instr          (instr),
    .din            (din),
    .empty          (empty),
    .full           (full),
    .pend           (pend),
    .wrap_target    (wrap_target),
    .pins_out_base  (pins_out_base),
    .pins_out_count (pins_out_count),
    .pins_set_base  (pins_set_base),
    .pins_set_count (pins_set_count),
    .pc             (pc),
    .push           (push),
    .pull           (pull),
    .dout           (dout),
    .output_pins    (output_pins),
    .pin_directions (pin_directions)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Inputs change 1 ns after each rising edge
  always @(posedge clk) begin : drive_inputs
    #1;
    cycle_count++;
    if (pull_taken) rd_idx++;
    rst_n = (cycle_count >= 3); // Low for the first 3 edges
    en    = (($random(seed) & 3) != 0);
    empty = (($random(seed) & 3) == 0);
    full  = (($random(seed) & 3) == 0);
    din   = fifo_words[rd_idx % 8];
  end

  // Strobes are stable at the falling edge
  always @(negedge clk) begin : watch_outputs
    pull_taken = pull;
    if (push) push_count++;
    if (i_dut.i_assertions.error_count != 0) begin
      $display("Checks failed");
      $fatal(1, "Assertion failure reported by the checker");
    end
  end

  initial begin : run_control
    seed           = 32'h1fa;
    cycle_count    = 0;
    push_count     = 0;
    rd_idx         = 0;
    pull_taken     = 1'b0;
    rst_n          = 1'b0;
    en             = 1'b0;
    empty          = 1'b1;
    full           = 1'b0;
    input_pins     = '0;
    jmp_pin        = 1'b0;
    pend           = 5'd9;
    wrap_target    = 5'd1;
    pins_out_base  = 5'd8;
    pins_out_count = 6'd4;
    pins_set_base  = 5'd0;
    pins_set_count = 3'd5;
    pins_in_base   = 5'd0;
    in_shift_dir   = 1'b1; // Both shifts to the right
    out_shift_dir  = 1'b1;
    fifo_words[0]  = 32'h1234_5678;
    fifo_words[1]  = 32'h9abc_def0;
    fifo_words[2]  = 32'h0f0f_a5a5;
    fifo_words[3]  = 32'hcafe_0042;
    fifo_words[4]  = 32'h8000_0001;
    fifo_words[5]  = 32'h7fff_fffe;
    fifo_words[6]  = 32'h0000_0000;
    fifo_words[7]  = 32'hffff_ffff;
    din            = fifo_words[0];
    load_program();
    wait (push_count >= push_target || cycle_count >= max_cycles);
    @(negedge clk);
    if (i_dut.i_assertions.error_count == 0 && push_count >= push_target) begin
      $display("All checks passed");
      $finish;
    end else begin
      if (push_count < push_target) begin
        $display("Timeout hit after %0d cycles with %0d of %0d pushes",
                 cycle_count, push_count, push_target);
      end
      $display("Checks failed");
      $fatal(1, "Run ended in failure");
    end
  end

endmodule

`default_nettype wire

//--- pio_machine.f
rtl/pio_pkg.sv
rtl/shift_in_unit.sv
rtl/shift_out_unit.sv
rtl/scratch_regs.sv
rtl/program_counter.sv
rtl/exec_ctrl.sv
rtl/pio_machine.sv
tests/pio_machine_assertions.sv
tests/pio_machine_tb.sv
